//--- vlog.f
hw/lsu_pkg.sv
hw/lsu_req_if.sv
hw/lsu_agu_mc.sv
hw/lsu_lsq.sv
hw/lsu_bus_ctrl.sv
hw/lsu_top.sv
verification/lsu_sva.sv
verification/lsu_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP      := lsu_tb
FILELIST := vlog.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- verification/lsu_tb.sv
module lsu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import lsu_pkg::*;

    localparam int LSQ_DEPTH   = 4;
    localparam int MEM_WORDS   = 64;
    localparam int REQ_TIMEOUT = 100;
    localparam int END_TIMEOUT = 2000;
    localparam int RANDOM_REQS = 200;

    typedef struct packed {
        rob_index_t rob_index;
        preg_addr_t rd_addr;
        logic       exc;
        ecause_t    ecause;
        xlen_t      data;
    } expect_t;

    logic       clk;
    logic       rst;
    logic       req_vld;
    logic       rdy;
    ls_opcode_e opcode;
    xlen_t      base;
    xlen_t      offset;
    xlen_t      st_data;
    rob_index_t rob_index;
    preg_addr_t rd_addr;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    xlen_t      wb_adr;
    xlen_t      wb_dat_w;
    wb_sel_t    wb_sel;
    logic       wb_ack;
    xlen_t      wb_dat_r;
    logic       comm_vld;
    rob_index_t comm_rob_index;
    preg_addr_t comm_rd_addr;
    xlen_t      comm_data;
    logic       comm_exc;
    ecause_t    comm_ecause;

    xlen_t      mem [MEM_WORDS];
    xlen_t      ref_mem [MEM_WORDS];
    expect_t    exp_q [$];
    integer     seed;
    logic       slow;
    logic [1:0] wait_pick;
    logic [1:0] wait_left;
    logic       hung;
    logic       stall_seen;
    int         stall_at;
    int         accepted;
    int         stb_cycles;
    int         checks;
    int         errors;
    int         test_err_base;
    int         tests_run;
    int         tests_failed;
    string      test_name;
    rob_index_t rob_next;

    lsu_top dut_i (
        .clk(clk), .rst(rst), .req_vld_i(req_vld), .rdy_o(rdy), .opcode_i(opcode),
        .base_i(base), .offset_i(offset), .data_i(st_data), .rob_index_i(rob_index),
        .rd_addr_i(rd_addr), .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we),
        .wb_adr_o(wb_adr), .wb_dat_o(wb_dat_w), .wb_sel_o(wb_sel), .wb_ack_i(wb_ack),
        .wb_dat_i(wb_dat_r), .comm_vld_o(comm_vld), .comm_rob_index_o(comm_rob_index),
        .comm_rd_addr_o(comm_rd_addr), .comm_data_o(comm_data), .comm_exc_o(comm_exc),
        .comm_ecause_o(comm_ecause)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // wait states for the next access, drawn between edges
    always @(negedge clk) begin
        wait_pick <= slow ? 2'd3 : 2'($random(seed));
    end

    // Wishbone slave, one ack per access after wait_left idle cycles
    always @(posedge clk) begin
        xlen_t w;
        wb_ack <= 1'b0;
        if (rst) begin
            wait_left <= 2'd0;
        end else if (!wb_cyc) begin
            wait_left <= wait_pick;
        end else if (wb_stb && !wb_ack) begin
            if (wait_left == 2'd0) begin
                w = mem[wb_adr[7:2]];
                for (int b = 0; b < 4; b++) begin
                    if (wb_we && wb_sel[b]) begin
                        w[8*b +: 8] = wb_dat_w[8*b +: 8];
                    end
                end
                mem[wb_adr[7:2]] <= w;
                wb_dat_r <= mem[wb_adr[7:2]];
                wb_ack   <= 1'b1;
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

    always @(negedge clk) begin
        if (wb_stb === 1'b1) begin
            stb_cycles++;
        end
    end

    function automatic xlen_t fill_word(int i);
        return xlen_t'(i + 1) * 32'h9e37_79b9;
    endfunction

    // expected commit; stores update the reference memory at acceptance
    function automatic expect_t predict_commit(ls_opcode_e op, xlen_t b, xlen_t off,
                                               xlen_t d, rob_index_t rob, preg_addr_t rd);
        expect_t e;
        xlen_t   addr;
        xlen_t   word;
        xlen_t   val;
        int      size;
        int      lane;
        logic    store;
        addr  = b + off;
        lane  = int'(addr[1:0]);
        word  = ref_mem[addr[7:2]];
        store = op inside {LS_SB, LS_SH, LS_SW};
        case (op)
            LS_LB, LS_LBU, LS_SB: size = 1;
            LS_LH, LS_LHU, LS_SH: size = 2;
            default:              size = 4;
        endcase
        e.rob_index = rob;
        e.rd_addr   = rd;
        e.exc       = (lane % size) != 0;
        e.ecause    = store ? ECAUSE_ST_MISALIGN : ECAUSE_LD_MISALIGN;
        e.data      = '0;
        val         = '0;
        if (!e.exc) begin
            for (int i = 0; i < size; i++) begin
                if (store) begin
                    word[8*(lane+i) +: 8] = d[8*i +: 8];
                end else begin
                    val[8*i +: 8] = word[8*(lane+i) +: 8];
                end
            end
            ref_mem[addr[7:2]] = word;
            case (op)
                LS_LB:   e.data = {{24{val[7]}}, val[7:0]};
                LS_LH:   e.data = {{16{val[15]}}, val[15:0]};
                LS_LBU, LS_LHU, LS_LW: e.data = val;
                default: e.data = '0;
            endcase
        end
        return e;
    endfunction

    task automatic check_data(xlen_t exp, xlen_t act);
        checks++;
        if (act !== exp) begin
            $display("CHECK FAILED %s: data expected 0x%h, got 0x%h", test_name, exp, act);
            errors++;
        end
    endtask

    task automatic check_rob(rob_index_t exp, rob_index_t act);
        checks++;
        if (act !== exp) begin
            $display("CHECK FAILED %s: rob index expected %0d, got %0d", test_name, exp, act);
            errors++;
        end
    endtask

    task automatic check_rd(preg_addr_t exp, preg_addr_t act);
        checks++;
        if (act !== exp) begin
            $display("CHECK FAILED %s: destination expected %0d, got %0d", test_name, exp, act);
            errors++;
        end
    endtask

    task automatic check_exc(logic exp, logic act);
        checks++;
        if (act !== exp) begin
            $display("CHECK FAILED %s: exception flag expected %b, got %b", test_name, exp, act);
            errors++;
        end
    endtask

    task automatic check_cause(ecause_t exp, ecause_t act);
        checks++;
        if (act !== exp) begin
            $display("CHECK FAILED %s: cause expected %0d, got %0d", test_name, exp, act);
            errors++;
        end
    endtask

    // commits must match the expected queue in acceptance order
    always @(negedge clk) begin
        expect_t e;
        if (!rst && comm_vld === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("commit for rob %0d with no request outstanding", comm_rob_index);
                errors++;
            end else begin
                e = exp_q.pop_front();
                check_rob(e.rob_index, comm_rob_index);
                check_rd(e.rd_addr, comm_rd_addr);
                check_exc(e.exc, comm_exc);
                if (e.exc) begin
                    check_cause(e.ecause, comm_ecause);
                end
                check_data(e.data, comm_data);
            end
        end
    end

    // returns just after the accepting edge, so requests can go back to back
    task automatic send_req(ls_opcode_e op, xlen_t b, xlen_t off, xlen_t d);
        int         waited;
        preg_addr_t rd;
        waited = 0;
        // destination kept apart from the rob index
        rd     = ~{1'b0, rob_next};
        if (!hung) begin
            req_vld   <= 1'b1;
            opcode    <= op;
            base      <= b;
            offset    <= off;
            st_data   <= d;
            rob_index <= rob_next;
            rd_addr   <= rd;
            @(negedge clk);
            while (!rdy && !hung) begin
                if (!stall_seen) begin
                    stall_seen = 1'b1;
                    stall_at   = accepted;
                end
                if (waited == REQ_TIMEOUT) begin
                    $display("timeout: rdy_o stayed low for %0d cycles in %s",
                             REQ_TIMEOUT, test_name);
                    hung = 1'b1;
                    errors++;
                    req_vld <= 1'b0;
                end else begin
                    waited++;
                    @(negedge clk);
                end
            end
            if (!hung) begin
                exp_q.push_back(predict_commit(op, b, off, d, rob_next, rd));
                accepted++;
                rob_next++;
                @(posedge clk);
            end
        end
    endtask

    task automatic idle(int n);
        req_vld <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        req_vld <= 1'b0;
        while (exp_q.size() != 0 && !hung) begin
            if (waited == END_TIMEOUT) begin
                $display("timeout: %0d commits still missing in %s", exp_q.size(), test_name);
                hung = 1'b1;
                errors++;
            end else begin
                waited++;
                @(posedge clk);
            end
        end
    endtask

    task automatic start_test(string name);
        test_name     = name;
        test_err_base = errors;
    endtask

    task automatic finish_test();
        drain();
        tests_run++;
        if (errors != test_err_base) begin
            tests_failed++;
            $display("%-16s failed, %0d errors", test_name, errors - test_err_base);
        end else begin
            $display("%-16s passed", test_name);
        end
    endtask

    initial begin
        int         base_stb;
        int         base_acc;
        ls_opcode_e r_op;
        xlen_t      r_base;
        xlen_t      r_off;
        xlen_t      r_data;
        seed       = 69;
        rst        = 1'b1;
        req_vld    = 1'b0;
        opcode     = LS_LW;
        base       = '0;
        offset     = '0;
        st_data    = '0;
        rob_index  = '0;
        rd_addr    = '0;
        wb_ack     = 1'b0;
        wb_dat_r   = '0;
        wait_pick  = 2'd0;
        slow       = 1'b0;
        hung       = 1'b0;
        stall_seen = 1'b0;
        stall_at   = 0;
        accepted   = 0;
        stb_cycles = 0;
        checks     = 0;
        errors     = 0;
        tests_run  = 0;
        tests_failed = 0;
        rob_next   = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]     = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        start_test("word_store_load");
        send_req(LS_SW, 32'h40, 32'h0, 32'hcafe_f00d);
        send_req(LS_LW, 32'h30, 32'h10, 32'h0);
        finish_test();

        // both words hold bytes and halfwords of either sign
        start_test("sub_word_loads");
        send_req(LS_SW, 32'h80, 32'h0, 32'h817f_80ff);
        send_req(LS_SW, 32'h84, 32'h0, 32'h7f80_017e);
        for (int a = 'h80; a < 'h88; a++) begin
            send_req(LS_LB, xlen_t'(a), 32'h0, 32'h0);
            send_req(LS_LBU, xlen_t'(a), 32'h0, 32'h0);
            if (a % 2 == 0) begin
                send_req(LS_LH, xlen_t'(a), 32'h0, 32'h0);
                send_req(LS_LHU, xlen_t'(a), 32'h0, 32'h0);
            end
        end
        finish_test();

        // upper store data bytes must not reach memory
        start_test("sub_word_stores");
        send_req(LS_SW, 32'hc0, 32'h0, 32'h0);
        for (int k = 0; k < 4; k++) begin
            send_req(LS_SB, 32'hc0, xlen_t'(k), 32'hab00 | xlen_t'(32'h11 * (k + 1)));
            send_req(LS_LW, 32'hc0, 32'h0, 32'h0);
        end
        send_req(LS_SH, 32'hc4, 32'h0, 32'h1234_beef);
        send_req(LS_LW, 32'hc4, 32'h0, 32'h0);
        send_req(LS_SH, 32'hc4, 32'h2, 32'h5678_0a0b);
        send_req(LS_LW, 32'hc4, 32'h0, 32'h0);
        finish_test();

        start_test("misaligned");
        base_stb = stb_cycles;
        send_req(LS_LH, 32'h00, 32'h1, 32'h0);
        send_req(LS_LHU, 32'h02, 32'h1, 32'h0);
        send_req(LS_LW, 32'h00, 32'h2, 32'h0);
        send_req(LS_LW, 32'h01, 32'h0, 32'h0);
        send_req(LS_SH, 32'h04, 32'h1, 32'h5555_aaaa);
        send_req(LS_SW, 32'h06, 32'h0, 32'h5555_aaaa);
        send_req(LS_SW, 32'h04, 32'h3, 32'h5555_aaaa);
        drain();
        if (stb_cycles != base_stb) begin
            $display("bus was active for %0d cycles on misaligned requests",
                     stb_cycles - base_stb);
            errors++;
        end
        finish_test();

        start_test("back_pressure");
        slow       = 1'b1;
        stall_seen = 1'b0;
        base_acc   = accepted;
        for (int k = 0; k < 2 * LSQ_DEPTH; k++) begin
            if (k % 2 == 0) begin
                send_req(LS_SW, xlen_t'(32'h20 + 4 * k), 32'h0, xlen_t'(32'h1111_0000 + k));
            end else begin
                send_req(LS_LW, xlen_t'(32'h1c + 4 * k), 32'h0, 32'h0);
            end
        end
        drain();
        slow = 1'b0;
        if (!stall_seen || stall_at - base_acc != LSQ_DEPTH) begin
            $display("rdy_o did not fall after exactly %0d outstanding requests", LSQ_DEPTH);
            errors++;
        end
        finish_test();

        start_test("random_mix");
        for (int k = 0; k < RANDOM_REQS; k++) begin
            r_op   = ls_opcode_e'(3'($random(seed)));
            r_base = xlen_t'($random(seed)) & 32'hfc;
            r_off  = xlen_t'($random(seed)) & 32'h7;
            r_data = xlen_t'($random(seed));
            send_req(r_op, r_base, r_off, r_data);
            if (2'($random(seed)) == 2'd0) begin
                idle(1);
            end
        end
        finish_test();

        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && !hung) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- verification/lsu_sva.sv
module lsu_sva (
    input logic                clk,
    input logic                rst,
    input lsu_pkg::bus_state_e state_i,
    input logic                wb_cyc_i,
    input logic                wb_stb_i,
    input logic                wb_we_i,
    input lsu_pkg::xlen_t      wb_adr_i,
    input lsu_pkg::wb_sel_t    wb_sel_i,
    input logic                wb_ack_i,
    input logic                comm_vld_i,
    input logic                comm_exc_i
);
    timeunit 1ns;
    timeprecision 1ps;

    import lsu_pkg::*;

    // the ack ends the bus cycle on the next edge
    cycle_ends_on_ack: assert property (@(posedge clk) disable iff (rst)
        wb_stb_i && wb_ack_i |=> !wb_stb_i && !wb_cyc_i)
        else $error("wb_cyc_o or wb_stb_o still high after the ack");

    // request held until the slave acks
    held_until_ack: assert property (@(posedge clk) disable iff (rst)
        wb_stb_i && !wb_ack_i |=> $stable(wb_adr_i) && $stable(wb_sel_i) && $stable(wb_we_i))
        else $error("address, select or write enable changed while waiting for ack");

    single_commit: assert property (@(posedge clk) disable iff (rst)
        comm_vld_i |=> !comm_vld_i)
        else $error("comm_vld_o high for two cycles in a row");

    // exception entries go from idle straight to commit
    exc_skips_bus: assert property (@(posedge clk) disable iff (rst)
        comm_vld_i && comm_exc_i |-> $past(state_i) == BUS_IDLE && !$past(wb_cyc_i))
        else $error("bus cycle ran for an exception entry");

endmodule

bind lsu_bus_ctrl lsu_sva sva_i (
    .clk        (clk),
    .rst        (rst),
    .state_i    (state),
    .wb_cyc_i   (wb_cyc_o),
    .wb_stb_i   (wb_stb_o),
    .wb_we_i    (wb_we_o),
    .wb_adr_i   (wb_adr_o),
    .wb_sel_i   (wb_sel_o),
    .wb_ack_i   (wb_ack_i),
    .comm_vld_i (comm_vld_o),
    .comm_exc_i (comm_exc_o)
);

//--- hw/lsu_top.sv
module lsu_top (
    input  logic                clk,
    input  logic                rst,

    // request side
    input  logic                req_vld_i,
    output logic                rdy_o,
    input  lsu_pkg::ls_opcode_e opcode_i,
    input  lsu_pkg::xlen_t      base_i,
    input  lsu_pkg::xlen_t      offset_i,
    input  lsu_pkg::xlen_t      data_i,
    input  lsu_pkg::rob_index_t rob_index_i,
    input  lsu_pkg::preg_addr_t rd_addr_i,

    // Wishbone
    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    output logic                wb_we_o,
    output lsu_pkg::xlen_t      wb_adr_o,
    output lsu_pkg::xlen_t      wb_dat_o,
    output lsu_pkg::wb_sel_t    wb_sel_o,
    input  logic                wb_ack_i,
    input  lsu_pkg::xlen_t      wb_dat_i,

    // commit
    output logic                comm_vld_o,
    output lsu_pkg::rob_index_t comm_rob_index_o,
    output lsu_pkg::preg_addr_t comm_rd_addr_o,
    output lsu_pkg::xlen_t      comm_data_o,
    output logic                comm_exc_o,
    output lsu_pkg::ecause_t    comm_ecause_o
);
    import lsu_pkg::*;

    lsq_entry_t entry;
    logic       enq;

    lsu_req_if req_if ();

    assign enq = req_vld_i & rdy_o;

    lsu_agu_mc agu_mc_i (
        .req_vld_i   (req_vld_i),
        .opcode_i    (opcode_i),
        .base_i      (base_i),
        .offset_i    (offset_i),
        .data_i      (data_i),
        .rob_index_i (rob_index_i),
        .rd_addr_i   (rd_addr_i),
        .entry_o     (entry)
    );

    lsu_lsq #(
        .LSQ_DEPTH (4)
    ) lsq_i (
        .clk     (clk),
        .rst     (rst),
        .enq_i   (enq),
        .entry_i (entry),
        .rdy_o   (rdy_o),
        .req     (req_if.queue)
    );

    lsu_bus_ctrl bus_ctrl_i (
        .clk              (clk),
        .rst              (rst),
        .req              (req_if.bus),
        .wb_cyc_o         (wb_cyc_o),
        .wb_stb_o         (wb_stb_o),
        .wb_we_o          (wb_we_o),
        .wb_adr_o         (wb_adr_o),
        .wb_dat_o         (wb_dat_o),
        .wb_sel_o         (wb_sel_o),
        .wb_ack_i         (wb_ack_i),
        .wb_dat_i         (wb_dat_i),
        .comm_vld_o       (comm_vld_o),
        .comm_rob_index_o (comm_rob_index_o),
        .comm_rd_addr_o   (comm_rd_addr_o),
        .comm_data_o      (comm_data_o),
        .comm_exc_o       (comm_exc_o),
        .comm_ecause_o    (comm_ecause_o)
    );

endmodule

//--- hw/lsu_bus_ctrl.sv
module lsu_bus_ctrl (
    input  logic                clk,
    input  logic                rst,
    lsu_req_if.bus              req,

    // Wishbone classic master
    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    output logic                wb_we_o,
    output lsu_pkg::xlen_t      wb_adr_o,
    output lsu_pkg::xlen_t      wb_dat_o,
    output lsu_pkg::wb_sel_t    wb_sel_o,
    input  logic                wb_ack_i,
    input  lsu_pkg::xlen_t      wb_dat_i,

    // commit
    output logic                comm_vld_o,
    output lsu_pkg::rob_index_t comm_rob_index_o,
    output lsu_pkg::preg_addr_t comm_rd_addr_o,
    output lsu_pkg::xlen_t      comm_data_o,
    output logic                comm_exc_o,
    output lsu_pkg::ecause_t    comm_ecause_o
);
    import lsu_pkg::*;

    bus_state_e state;
    bus_state_e state_nxt;

    logic       access;
    logic [4:0] lane_shift;
    xlen_t      rd_shifted;
    xlen_t      ld_data;

    assign access     = state == BUS_ACCESS;
    assign lane_shift = {req.head.addr[1:0], 3'b000};

    // exception entries skip the bus and go straight to commit
    always_comb begin
        state_nxt = state;
        case (state)
            BUS_IDLE: begin
                if (req.head_vld) begin
                    state_nxt = req.head.exc ? BUS_COMMIT : BUS_ACCESS;
                end
            end
            BUS_ACCESS: begin
                if (wb_ack_i) begin
                    state_nxt = BUS_COMMIT;
                end
            end
            default: state_nxt = BUS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= BUS_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign req.head_pop = (state == BUS_IDLE && req.head_vld && req.head.exc) ||
                          (access && wb_ack_i);

    // bus signals held by the head entry until the ack pops it
    assign wb_cyc_o = access;
    assign wb_stb_o = access;
    assign wb_we_o  = access & ls_is_store(req.head.opcode);
    assign wb_adr_o = {req.head.addr[XLEN-1:2], 2'b00};
    assign wb_sel_o = ls_size_mask(req.head.opcode) << req.head.addr[1:0];
    assign wb_dat_o = req.head.data << lane_shift;

    // move the addressed lanes down, then extend
    assign rd_shifted = wb_dat_i >> lane_shift;

    always_comb begin
        case (req.head.opcode)
            LS_LB:   ld_data = {{24{rd_shifted[7]}}, rd_shifted[7:0]};
            LS_LBU:  ld_data = {24'h0, rd_shifted[7:0]};
            LS_LH:   ld_data = {{16{rd_shifted[15]}}, rd_shifted[15:0]};
            LS_LHU:  ld_data = {16'h0, rd_shifted[15:0]};
            LS_LW:   ld_data = rd_shifted;
            default: ld_data = '0;
        endcase
    end

    // commit payload, captured with the pop
    always_ff @(posedge clk) begin
        if (req.head_pop) begin
            comm_rob_index_o <= req.head.rob_index;
            comm_rd_addr_o   <= req.head.rd_addr;
            comm_ecause_o    <= req.head.ecause;
            comm_data_o      <= req.head.exc ? '0 : ld_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            comm_exc_o <= 1'b0;
        end else if (req.head_pop) begin
            comm_exc_o <= req.head.exc;
        end
    end

    // one commit state per entry, always followed by idle
    assign comm_vld_o = state == BUS_COMMIT;

endmodule

//--- hw/lsu_lsq.sv
module lsu_lsq #(
    parameter int LSQ_DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                enq_i,
    input  lsu_pkg::lsq_entry_t entry_i,
    output logic                rdy_o,
    lsu_req_if.queue            req
);
    import lsu_pkg::*;

    // storage, no reset needed
    lsq_entry_t mem [LSQ_DEPTH];

    logic [$clog2(LSQ_DEPTH)-1:0] head_ptr;
    logic [$clog2(LSQ_DEPTH)-1:0] tail_ptr;

    // one extra bit so a full queue is distinct from an empty one
    logic [$clog2(LSQ_DEPTH):0]   count;

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            // pointers wrap on their own, depth is a power of two
            if (enq_i) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (req.head_pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
            case ({enq_i, req.head_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (enq_i) begin
            mem[tail_ptr] <= entry_i;
        end
    end

    assign rdy_o        = count != ($clog2(LSQ_DEPTH) + 1)'(LSQ_DEPTH);
    assign req.head_vld = count != '0;
    assign req.head     = mem[head_ptr];

endmodule

//--- hw/lsu_agu_mc.sv
module lsu_agu_mc (
    input  logic                req_vld_i,
    input  lsu_pkg::ls_opcode_e opcode_i,
    input  lsu_pkg::xlen_t      base_i,
    input  lsu_pkg::xlen_t      offset_i,
    input  lsu_pkg::xlen_t      data_i,
    input  lsu_pkg::rob_index_t rob_index_i,
    input  lsu_pkg::preg_addr_t rd_addr_i,
    output lsu_pkg::lsq_entry_t entry_o
);
    import lsu_pkg::*;

    xlen_t   addr;
    wb_sel_t size_mask;
    logic    misaligned;

    // physical address is the virtual one, no translation
    assign addr      = base_i + offset_i;
    assign size_mask = ls_size_mask(opcode_i);

    // halfword needs bit 0 clear, word needs both low bits clear
    always_comb begin
        case (size_mask)
            4'b0011: misaligned = addr[0];
            4'b1111: misaligned = addr[1:0] != 2'b00;
            default: misaligned = 1'b0;
        endcase
    end

    always_comb begin
        entry_o.opcode    = opcode_i;
        entry_o.addr      = addr;
        entry_o.data      = data_i;
        entry_o.rob_index = rob_index_i;
        entry_o.rd_addr   = rd_addr_i;
        // flag only raised for a live request
        entry_o.exc       = req_vld_i & misaligned;
        entry_o.ecause    = ls_is_store(opcode_i) ? ECAUSE_ST_MISALIGN : ECAUSE_LD_MISALIGN;
    end

endmodule

//--- hw/lsu_req_if.sv
interface lsu_req_if;
    import lsu_pkg::*;

    // head of the queue, valid while the queue holds an entry
    logic       head_vld;
    lsq_entry_t head;

    // one-cycle pulse, only while head_vld is high
    logic       head_pop;

    modport queue (
        output head_vld,
        output head,
        input  head_pop
    );

    modport bus (
        input  head_vld,
        input  head,
        output head_pop
    );

endinterface

//--- hw/lsu_pkg.sv
package lsu_pkg;

    // datapath and tag widths
    localparam int XLEN            = 32;
    localparam int ROB_INDEX_WIDTH = 5;
    localparam int PREG_ADDR_WIDTH = 6;
    localparam int ECAUSE_WIDTH    = 4;
    localparam int WB_SEL_WIDTH    = 4;

    typedef logic [XLEN-1:0]            xlen_t;
    typedef logic [ROB_INDEX_WIDTH-1:0] rob_index_t;
    typedef logic [PREG_ADDR_WIDTH-1:0] preg_addr_t;
    typedef logic [ECAUSE_WIDTH-1:0]    ecause_t;
    typedef logic [WB_SEL_WIDTH-1:0]    wb_sel_t;

    // RISC-V mcause codes for misaligned accesses
    localparam ecause_t ECAUSE_LD_MISALIGN = 4'd4;
    localparam ecause_t ECAUSE_ST_MISALIGN = 4'd6;

    // loads first, stores last
    typedef enum logic [2:0] {
        LS_LB,
        LS_LH,
        LS_LW,
        LS_LBU,
        LS_LHU,
        LS_SB,
        LS_SH,
        LS_SW
    } ls_opcode_e;

    // one queued request, 83 bits
    typedef struct packed {
        ls_opcode_e opcode;
        xlen_t      addr;
        xlen_t      data;
        rob_index_t rob_index;
        preg_addr_t rd_addr;
        logic       exc;
        ecause_t    ecause;
    } lsq_entry_t;

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_ACCESS,
        BUS_COMMIT
    } bus_state_e;

    function automatic logic ls_is_store(ls_opcode_e op);
        return (op == LS_SB) || (op == LS_SH) || (op == LS_SW);
    endfunction

    // byte lanes touched by an access at offset zero
    function automatic wb_sel_t ls_size_mask(ls_opcode_e op);
        case (op)
            LS_LB, LS_LBU, LS_SB: return 4'b0001;
            LS_LH, LS_LHU, LS_SH: return 4'b0011;
            default:              return 4'b1111;
        endcase
    endfunction

endpackage
